// ==== Makefile ====
SOURCES := $(shell cat snoop_channel.f)

.PHONY: all run clean

all: obj_dir/Vtb_snoop_channel

obj_dir/Vtb_snoop_channel: snoop_channel.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_snoop_channel -f snoop_channel.f -o Vtb_snoop_channel

run: obj_dir/Vtb_snoop_channel
	./obj_dir/Vtb_snoop_channel > sim.log 2>&1; cat sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/snoop_pkg.sv ====
// shared field widths of the snoop channel bridge, imported by RTL and testbench
`default_nettype none

package snoop_pkg;

  // ************************************************************************
  // request channel (AC) fields
  // ************************************************************************
  parameter int pa_width    = 40;
  parameter int snoop_width = 4;
  parameter int prot_width  = 3;

  // one buffered request: address on top, then snoop type, then protection
  parameter int ac_word_width = pa_width + snoop_width + prot_width;

  // ************************************************************************
  // response (CR) and data (CD) channel fields
  // ************************************************************************
  parameter int resp_width    = 5;
  parameter int cd_data_width = 128;

  // one buffered data entry: last flag above the data beat
  parameter int cd_word_width = cd_data_width + 1;

endpackage

`default_nettype wire

// ==== snoop_channel.f ====
common/snoop_pkg.sv
verilog/snoop_pingpong_buf.sv
verilog/snoop_ac_path.sv
verilog/snoop_channel.sv
verif/tb_clk_gen.sv
verif/tb_snoop_channel.sv

// ==== verif/tb_clk_gen.sv ====
// testbench clock and reset source for the snoop bridge, instantiated by the testbench top
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int half_period  = 5,
  parameter int reset_cycles = 5
) (
  output logic accpuclk,
  output logic cpurst_b
);

  initial
  begin
    accpuclk = 1'b0;
    forever
      #(half_period) accpuclk = ~accpuclk;
  end

  // reset released on a rising edge, like the rest of the stimulus
  initial
  begin
    cpurst_b = 1'b0;
    repeat (reset_cycles)
      @(posedge accpuclk);
    cpurst_b <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/tb_snoop_channel.sv ====
// top-level testbench that drives every snoop channel of the bridge against reference queues
`default_nettype none
`timescale 1ns/1ps

module tb_snoop_channel;

  import snoop_pkg::*;

  localparam int n_items     = 200;
  // 200-item tests at up to about 6 cycles per item plus margin
  localparam int cycle_limit = 6000;
  localparam int cmp_width   = cd_word_width;

  logic                     accpuclk;
  logic                     cpurst_b;
  logic                     acvalid;
  logic                     acready;
  logic [pa_width-1:0]      acaddr;
  logic [snoop_width-1:0]   acsnoop;
  logic [prot_width-1:0]    acprot;
  logic                     crvalid;
  logic                     crready;
  logic [resp_width-1:0]    crresp;
  logic                     cdvalid;
  logic                     cdready;
  logic [cd_data_width-1:0] cddata;
  logic                     cdlast;
  logic                     ac_req;
  logic                     ac_ready;
  logic [pa_width-1:0]      ac_addr;
  logic [snoop_width-1:0]   ac_snoop;
  logic [prot_width-1:0]    ac_prot;
  logic                     ac_empty;
  logic                     cr_valid;
  logic                     cr_ready;
  logic [resp_width-1:0]    cr_resp;
  logic                     cd_valid;
  logic                     cd_ready;
  logic [cd_data_width-1:0] cd_data;
  logic                     cd_last;
  logic                     snoop_vld;

  // one entry per item currently inside the bridge
  logic [ac_word_width-1:0] ac_q [$];
  logic [resp_width-1:0]    cr_q [$];
  logic [cd_word_width-1:0] cd_q [$];
  logic                     vld_exp;

  string cur_test;
  int    run_errs = 0;
  int    chk_errs = 0;
  int    errs_at_start = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    cycle_count = 0;

  tb_clk_gen #(.half_period(5), .reset_cycles(5)) i_clk_gen (
    .accpuclk (accpuclk),
    .cpurst_b (cpurst_b)
  );

  snoop_channel i_snoop_channel (.*);

  // **************************************************************************
  // helpers take a channel index where 0 is AC, 1 is CR and 2 is CD
  // **************************************************************************
  function automatic int total_errs();
    return run_errs + chk_errs;
  endfunction

  function automatic void note_failure(string msg);
    $display("%s: %s", cur_test, msg);
    chk_errs++;
  endfunction

  function automatic void match_head(string what, logic [cmp_width-1:0] exp,
                                     logic [cmp_width-1:0] act);
    head_check: assert (exp == act)
    else
    begin
      $display("ERR %s %s expected %0h actual %0h", cur_test, what, exp, act);
      chk_errs++;
    end
  endfunction

  function automatic logic in_valid(int c);
    case (c)
      0: return acvalid;
      1: return cr_valid;
      default: return cd_valid;
    endcase
  endfunction

  function automatic logic in_fire(int c);
    case (c)
      0: return acvalid && acready;
      1: return cr_valid && cr_ready;
      default: return cd_valid && cd_ready;
    endcase
  endfunction

  function automatic logic out_fire(int c);
    case (c)
      0: return ac_req && ac_ready;
      1: return crvalid && crready;
      default: return cdvalid && cdready;
    endcase
  endfunction

  // new random payload on every call
  task automatic drive_item(input int c, input logic v);
    case (c)
      0:
      begin
        acvalid <= v;
        acaddr  <= pa_width'({$urandom(), $urandom()});
        acsnoop <= snoop_width'($urandom());
        acprot  <= prot_width'($urandom());
      end
      1:
      begin
        cr_valid <= v;
        cr_resp  <= resp_width'($urandom());
      end
      default:
      begin
        cd_valid <= v;
        cd_data  <= cd_data_width'({$urandom(), $urandom(), $urandom(), $urandom()});
        cd_last  <= 1'($urandom_range(0, 1));
      end
    endcase
  endtask

  task automatic set_ready(input int c, input logic v);
    case (c)
      0: ac_ready <= v;
      1: crready <= v;
      default: cdready <= v;
    endcase
  endtask

  // source side that holds each payload until its handshake
  task automatic send_items(input int c, input int n);
    int sent;
    sent = 0;
    while (sent < n)
    begin
      @(posedge accpuclk);
      if (in_fire(c))
        sent++;
      if (!in_valid(c) || in_fire(c))
        drive_item(c, sent < n && $urandom_range(0, 3) != 0);
    end
  endtask

  // sink side with a random ready pattern
  task automatic take_items(input int c, input int n);
    int got;
    got = 0;
    while (got < n)
    begin
      @(posedge accpuclk);
      if (out_fire(c))
        got++;
      set_ready(c, got < n && $urandom_range(0, 1) == 1);
    end
  endtask

  task automatic check_backpressure(input int c);
    int taken;
    taken = 0;
    // sink ready is low here, so only two items fit
    repeat (8)
    begin
      @(posedge accpuclk);
      if (in_fire(c))
        taken++;
      if (!in_valid(c) || in_fire(c))
        drive_item(c, 1'b1);
    end
    @(negedge accpuclk);
    bp_count: assert (taken == 2)
    else
    begin
      $display("ERR %s accepted items expected 2 actual %0d", cur_test, taken);
      run_errs++;
    end
    bp_ready: assert (in_valid(c) && !in_fire(c))
    else
    begin
      $display("%s: input ready came back with both entries full", cur_test);
      run_errs++;
    end
    fork
      take_items(c, 3);
      begin
        @(posedge accpuclk);
        while (!in_fire(c))
          @(posedge accpuclk);
        drive_item(c, 1'b0);
      end
    join
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    errs_at_start = total_errs();
  endtask

  task automatic finish_test();
    @(negedge accpuclk);
    drained: assert (ac_q.size() == 0 && cr_q.size() == 0 && cd_q.size() == 0)
    else
    begin
      $display("%s: items were sent but never came out", cur_test);
      run_errs++;
    end
    tests_run++;
    if (total_errs() != errs_at_start)
    begin
      tests_failed++;
      $display("test %s failed", cur_test);
    end
    else
      $display("test %s ok", cur_test);
  endtask

  // **************************************************************************
  // scoreboard
  // **************************************************************************
  always @(posedge accpuclk)
  begin : scoreboard
    if (!cpurst_b)
    begin
      ac_q.delete();
      cr_q.delete();
      cd_q.delete();
      vld_exp = 1'b0;
    end
    else
    begin
      flag_check: assert (snoop_vld == vld_exp)
      else
      begin
        $display("ERR %s snoop_vld expected %0b actual %0b", cur_test, vld_exp, snoop_vld);
        chk_errs++;
      end
      // queue sizes here still describe the cycle that just ended
      if (acvalid && acready)
        vld_exp = 1'b1;
      else if (ac_empty && cr_q.size() == 0 && cd_q.size() == 0)
        vld_exp = 1'b0;

      if (ac_req && ac_ready)
      begin
        if (ac_q.size() == 0)
          note_failure("request came out that was never sent");
        else
          match_head("request", cmp_width'(ac_q.pop_front()),
                     cmp_width'({ac_addr, ac_snoop, ac_prot}));
      end
      if (crvalid && crready)
      begin
        if (cr_q.size() == 0)
          note_failure("response came out that was never sent");
        else
          match_head("response", cmp_width'(cr_q.pop_front()), cmp_width'(crresp));
      end
      if (cdvalid && cdready)
      begin
        if (cd_q.size() == 0)
          note_failure("data beat came out that was never sent");
        else
          match_head("data", cmp_width'(cd_q.pop_front()), cmp_width'({cdlast, cddata}));
      end

      if (acvalid && acready)
        ac_q.push_back({acaddr, acsnoop, acprot});
      if (cr_valid && cr_ready)
        cr_q.push_back(cr_resp);
      if (cd_valid && cd_ready)
        cd_q.push_back({cd_last, cd_data});
    end
  end

  // outputs hold still while waiting for ready
  ac_stable: assert property (@(posedge accpuclk) disable iff (!cpurst_b)
    (ac_req && !ac_ready) |=> (ac_req && $stable({ac_addr, ac_snoop, ac_prot})))
  else note_failure("request changed while waiting for ac_ready");

  cr_stable: assert property (@(posedge accpuclk) disable iff (!cpurst_b)
    (crvalid && !crready) |=> (crvalid && $stable(crresp)))
  else note_failure("response changed while waiting for crready");

  cd_stable: assert property (@(posedge accpuclk) disable iff (!cpurst_b)
    (cdvalid && !cdready) |=> (cdvalid && $stable({cddata, cdlast})))
  else note_failure("data beat changed while waiting for cdready");

  vld_rise: assert property (@(posedge accpuclk) disable iff (!cpurst_b)
    (acvalid && acready) |=> snoop_vld)
  else note_failure("snoop_vld low in the cycle after an accepted request");

  // **************************************************************************
  // test sequence
  // **************************************************************************
  initial
  begin
    void'($urandom(32'h7551bf92));
    acvalid  = 1'b0;
    acaddr   = '0;
    acsnoop  = '0;
    acprot   = '0;
    crready  = 1'b0;
    cdready  = 1'b0;
    ac_ready = 1'b0;
    ac_empty = 1'b1;
    cr_valid = 1'b0;
    cr_resp  = '0;
    cd_valid = 1'b0;
    cd_data  = '0;
    cd_last  = 1'b0;
    cur_test = "reset";
    wait (cpurst_b === 1'b1);

    start_test("reset_state");
    @(negedge accpuclk);
    // ac_req crvalid cdvalid snoop_vld low, acready cr_ready cd_ready high
    reset_values: assert ({ac_req, crvalid, cdvalid, snoop_vld, acready, cr_ready, cd_ready}
                          == 7'b0000111)
    else
    begin
      $display("ERR %s outputs expected %b actual %b", cur_test, 7'b0000111,
               {ac_req, crvalid, cdvalid, snoop_vld, acready, cr_ready, cd_ready});
      run_errs++;
    end
    finish_test();

    start_test("ac_order");
    fork
      send_items(0, n_items);
      take_items(0, n_items);
      begin
        repeat (n_items)
        begin
          @(posedge accpuclk);
          ac_empty <= 1'($urandom_range(0, 1));
        end
        ac_empty <= 1'b1;
      end
    join
    finish_test();

    for (int c = 0; c < 3; c++)
    begin
      start_test(c == 0 ? "ac_backpressure" : (c == 1 ? "cr_backpressure" : "cd_backpressure"));
      check_backpressure(c);
      finish_test();
    end

    start_test("cr_order");
    fork
      send_items(1, n_items);
      take_items(1, n_items);
    join
    finish_test();

    start_test("cd_order");
    fork
      send_items(2, n_items);
      take_items(2, n_items);
    join
    finish_test();

    // flag held by ac_empty, then by response and data, then by data alone
    start_test("activity");
    @(posedge accpuclk);
    ac_empty <= 1'b0;
    send_items(0, 1);
    take_items(0, 1);
    repeat (4)
      @(posedge accpuclk);
    fork
      send_items(1, 1);
      send_items(2, 1);
    join
    ac_empty <= 1'b1;
    repeat (4)
      @(posedge accpuclk);
    take_items(1, 1);
    repeat (4)
      @(posedge accpuclk);
    take_items(2, 1);
    repeat (3)
      @(posedge accpuclk);
    // response queued ahead of the request holds the flag on its own
    send_items(1, 1);
    send_items(0, 1);
    take_items(0, 1);
    repeat (4)
      @(posedge accpuclk);
    take_items(1, 1);
    repeat (3)
      @(posedge accpuclk);
    finish_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs());
    if (total_errs() == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  initial
  begin : watchdog
    while (cycle_count < cycle_limit)
    begin
      @(posedge accpuclk);
      cycle_count++;
    end
    $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/snoop_ac_path.sv ====
// snoop request path: request buffer toward the load/store unit plus activity flag
`default_nettype none
`timescale 1ns/1ps

module snoop_ac_path (
  input  logic                         accpuclk,
  input  logic                         cpurst_b,
  // interconnect side
  input  logic                         acvalid,
  output logic                         acready,
  input  logic [snoop_pkg::pa_width-1:0]    acaddr,
  input  logic [snoop_pkg::snoop_width-1:0] acsnoop,
  input  logic [snoop_pkg::prot_width-1:0]  acprot,
  // load/store side
  output logic                         ac_req,
  input  logic                         ac_ready,
  output logic [snoop_pkg::pa_width-1:0]    ac_addr,
  output logic [snoop_pkg::snoop_width-1:0] ac_snoop,
  output logic [snoop_pkg::prot_width-1:0]  ac_prot,
  // activity
  input  logic                         ac_empty,
  input  logic                         cr_pending,
  input  logic                         cd_pending,
  output logic                         snoop_vld
);

  import snoop_pkg::*;

  logic [ac_word_width-1:0] ac_in_word;
  logic [ac_word_width-1:0] ac_out_word;
  logic                     ac_accept;
  logic                     snoop_idle;

  // **************************************************************************
  // request buffer
  // **************************************************************************
  // word layout: | addr | snoop | prot |
  assign ac_in_word = {acaddr, acsnoop, acprot};

  snoop_pingpong_buf #(
    .width     (ac_word_width)
  ) i_ac_buf (
    .accpuclk  (accpuclk),
    .cpurst_b  (cpurst_b),
    .in_valid  (acvalid),
    .in_ready  (acready),
    .in_data   (ac_in_word),
    .out_valid (ac_req),
    .out_ready (ac_ready),
    .out_data  (ac_out_word)
  );

  assign ac_addr  = ac_out_word[ac_word_width-1 -: pa_width];
  assign ac_snoop = ac_out_word[prot_width +: snoop_width];
  assign ac_prot  = ac_out_word[prot_width-1:0];

  // **************************************************************************
  // snoop activity flag
  // **************************************************************************
  assign ac_accept  = acvalid && acready;

  // nothing left in the LSU and nothing waiting to go back out
  assign snoop_idle = ac_empty && !cr_pending && !cd_pending;

  // a new request wins over idle in the same cycle
  always_ff @(posedge accpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      snoop_vld <= 1'b0;
    else if (ac_accept)
      snoop_vld <= 1'b1;
    else if (snoop_idle)
      snoop_vld <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== verilog/snoop_channel.sv ====
// snoop channel bridge top: AC toward the LSU, CR and CD back to the interconnect
`default_nettype none
`timescale 1ns/1ps

module snoop_channel #(
  parameter int cd_width = snoop_pkg::cd_word_width
) (
  input  logic                                accpuclk,
  input  logic                                cpurst_b,
  // ************************************************************************
  // interconnect side
  // ************************************************************************
  input  logic                                acvalid,
  output logic                                acready,
  input  logic [snoop_pkg::pa_width-1:0]      acaddr,
  input  logic [snoop_pkg::snoop_width-1:0]   acsnoop,
  input  logic [snoop_pkg::prot_width-1:0]    acprot,
  output logic                                crvalid,
  input  logic                                crready,
  output logic [snoop_pkg::resp_width-1:0]    crresp,
  output logic                                cdvalid,
  input  logic                                cdready,
  output logic [snoop_pkg::cd_data_width-1:0] cddata,
  output logic                                cdlast,
  // ************************************************************************
  // load/store side
  // ************************************************************************
  output logic                                ac_req,
  input  logic                                ac_ready,
  output logic [snoop_pkg::pa_width-1:0]      ac_addr,
  output logic [snoop_pkg::snoop_width-1:0]   ac_snoop,
  output logic [snoop_pkg::prot_width-1:0]    ac_prot,
  input  logic                                ac_empty,
  input  logic                                cr_valid,
  output logic                                cr_ready,
  input  logic [snoop_pkg::resp_width-1:0]    cr_resp,
  input  logic                                cd_valid,
  output logic                                cd_ready,
  input  logic [snoop_pkg::cd_data_width-1:0] cd_data,
  input  logic                                cd_last,
  // activity
  output logic                                snoop_vld
);

  import snoop_pkg::*;

  logic [cd_width-1:0] cd_in_word;
  logic [cd_width-1:0] cd_out_word;

  // **************************************************************************
  // request path (AC) with activity flag
  // **************************************************************************
  // crvalid and cdvalid mark items still inside the bridge
  snoop_ac_path i_ac_path (
    .accpuclk   (accpuclk),
    .cpurst_b   (cpurst_b),
    .acvalid    (acvalid),
    .acready    (acready),
    .acaddr     (acaddr),
    .acsnoop    (acsnoop),
    .acprot     (acprot),
    .ac_req     (ac_req),
    .ac_ready   (ac_ready),
    .ac_addr    (ac_addr),
    .ac_snoop   (ac_snoop),
    .ac_prot    (ac_prot),
    .ac_empty   (ac_empty),
    .cr_pending (crvalid),
    .cd_pending (cdvalid),
    .snoop_vld  (snoop_vld)
  );

  // **************************************************************************
  // response path (CR)
  // **************************************************************************
  snoop_pingpong_buf #(
    .width     (resp_width)
  ) i_cr_buf (
    .accpuclk  (accpuclk),
    .cpurst_b  (cpurst_b),
    .in_valid  (cr_valid),
    .in_ready  (cr_ready),
    .in_data   (cr_resp),
    .out_valid (crvalid),
    .out_ready (crready),
    .out_data  (crresp)
  );

  // **************************************************************************
  // data path (CD)
  // **************************************************************************
  // last flag rides above the data beat
  assign cd_in_word = {cd_last, cd_data};

  snoop_pingpong_buf #(
    .width     (cd_width)
  ) i_cd_buf (
    .accpuclk  (accpuclk),
    .cpurst_b  (cpurst_b),
    .in_valid  (cd_valid),
    .in_ready  (cd_ready),
    .in_data   (cd_in_word),
    .out_valid (cdvalid),
    .out_ready (cdready),
    .out_data  (cd_out_word)
  );

  assign cddata = cd_out_word[cd_data_width-1:0];
  assign cdlast = cd_out_word[cd_data_width];

endmodule

`default_nettype wire

// ==== verilog/snoop_pingpong_buf.sv ====
// two-entry in-order valid/ready buffer, instantiated once per snoop channel
`default_nettype none
`timescale 1ns/1ps

module snoop_pingpong_buf #(
  parameter int width = 8
) (
  input  logic             accpuclk,
  input  logic             cpurst_b,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [width-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [width-1:0] out_data
);

  // **************************************************************************
  // entry storage
  // **************************************************************************
  logic             entry_vld [0:1];
  logic [width-1:0] entry_data [0:1];

  // write and read pointers, one bit each for two entries
  logic             wr_sel;
  logic             rd_sel;

  logic             push;
  logic             pop;

  // **************************************************************************
  // handshakes
  // **************************************************************************
  // ready only looks at occupancy, never at out_ready
  assign in_ready  = !entry_vld[0] || !entry_vld[1];
  assign push      = in_valid && in_ready;

  // entries fill alternately, so the one at rd_sel is the oldest
  assign out_valid = entry_vld[0] || entry_vld[1];
  assign pop       = out_valid && out_ready;

  // **************************************************************************
  // pointers
  // **************************************************************************
  always_ff @(posedge accpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wr_sel <= 1'b0;
    else if (push)
      wr_sel <= !wr_sel;
  end

  always_ff @(posedge accpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rd_sel <= 1'b0;
    else if (pop)
      rd_sel <= !rd_sel;
  end

  // **************************************************************************
  // entry valid bits
  // **************************************************************************
  // push needs a free entry and pop a full one,
  // so one entry never sees both in the same cycle
  always_ff @(posedge accpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      entry_vld[0] <= 1'b0;
      entry_vld[1] <= 1'b0;
    end
    else
    begin
      for (int i = 0; i < 2; i++)
      begin
        if (push && (wr_sel == 1'(i)))
          entry_vld[i] <= 1'b1;
        else if (pop && (rd_sel == 1'(i)))
          entry_vld[i] <= 1'b0;
      end
    end
  end

  // payload, written only into a free entry
  always_ff @(posedge accpuclk)
  begin
    if (push)
      entry_data[wr_sel] <= in_data;
  end

  // **************************************************************************
  // output mux
  // **************************************************************************
  assign out_data = entry_data[rd_sel];

endmodule

`default_nettype wire
